// ==== design/camera_config.svh ====
// ==========================================================
// Camera pipeline defaults
// ==========================================================
`ifndef CAMERA_CONFIG_SVH
`define CAMERA_CONFIG_SVH

// Raw Bayer sample width from the sensor
`define CAM_SAMPLE_W 12

// Maximum raw samples per line held in the line buffer
`define CAM_LINE_W 1280

// Frame rate window length in pixel clocks
// 25 MHz pixel clock gives a one second window
`define CAM_RATE_WINDOW 25000000

`endif

// ==== design/camera_pkg.sv ====
// ==========================================================
// Camera pipeline types
// ==========================================================
`include "camera_config.svh"

package camera_pkg;

  // One raw sensor sample, also one full-depth colour channel
  typedef logic [`CAM_SAMPLE_W-1:0] sample_t;

  // Column or row index of a raw sample
  typedef logic [11:0] coord_t;

  // Reduced colour channel or hue value
  typedef logic [7:0] chan8_t;

  // Packed output word, RGB555 or hue
  typedef logic [15:0] pixel_word_t;

  typedef enum logic [1:0] {
    idle,
    wait_frame,
    capturing
  } capture_state_e;

  typedef enum logic {
    fmt_hue,
    fmt_rgb555
  } out_fmt_e;

  // Channel holding the maximum, gray when all channels equal
  typedef enum logic [1:0] {
    sector_red,
    sector_green,
    sector_blue,
    sector_gray
  } hue_sector_e;

endpackage

// ==== design/pixel_if.sv ====
// ==========================================================
// Pixel stream interfaces
// ==========================================================
`timescale 1ns/1ns

// Raw Bayer samples with their coordinates
interface bayer_if;
  import camera_pkg::*;
  logic    valid;
  sample_t sample;
  coord_t  col;
  coord_t  row;
  modport src (output valid, sample, col, row);
  modport dst (input valid, sample, col, row);
endinterface

// Demosaiced RGB pixels, full sample depth per channel
interface rgb_if;
  import camera_pkg::*;
  logic    valid;
  sample_t red;
  sample_t green;
  sample_t blue;
  modport src (output valid, red, green, blue);
  modport dst (input valid, red, green, blue);
endinterface

// ==== design/frame_capture.sv ====
// ==========================================================
// Camera frame capture
// ==========================================================
`timescale 1ns/1ns

module frame_capture (
  input  logic               ccd_pixel_clk,
  input  logic               hps_fpga_reset_n,
  input  camera_pkg::sample_t ccd_data,
  input  logic               ccd_fval,
  input  logic               ccd_lval,
  input  logic               capture_start,
  bayer_if.src               bayer,
  output logic               frame_done
);
  import camera_pkg::*;

  // Pin register stage
  sample_t data_q;
  logic    fval_q;
  logic    lval_q;
  logic    fval_d;

  // Accept stage
  sample_t acc_data;
  logic    acc_valid;
  logic    acc_lval;
  logic    acc_start;
  logic    acc_end;

  // Output stage counters
  coord_t col_cnt;
  coord_t row_cnt;
  logic   line_seen;

  capture_state_e state;
  logic fval_rise;
  logic fval_fall;
  logic go;
  logic accept;

  assign fval_rise = fval_q & ~fval_d;
  assign fval_fall = ~fval_q & fval_d;
  // Only a fresh frame start opens capture, running frames are skipped
  assign go        = capture_start & fval_rise & (state != capturing);
  assign accept    = fval_q & lval_q & ((state == capturing) | go);

  // ==========================================================
  // Pin registers and capture FSM
  // ==========================================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= ccd_data;
    if (!hps_fpga_reset_n) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
      state  <= idle;
    end else begin
      fval_q <= ccd_fval;
      lval_q <= ccd_lval;
      fval_d <= fval_q;
      case (state)
        idle, wait_frame: begin
          if (go) begin
            state <= capturing;
          end else begin
            state <= capture_start ? wait_frame : idle;
          end
        end
        capturing: begin
          // Frame end, rearm only while start is still held
          if (fval_fall) begin
            state <= capture_start ? wait_frame : idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // ==========================================================
  // Accept stage
  // ==========================================================
  always_ff @(posedge ccd_pixel_clk) begin
    acc_data <= data_q;
    if (!hps_fpga_reset_n) begin
      acc_valid <= 1'b0;
      acc_lval  <= 1'b0;
      acc_start <= 1'b0;
      acc_end   <= 1'b0;
    end else begin
      acc_valid <= accept;
      acc_lval  <= lval_q;
      acc_start <= go;
      acc_end   <= (state == capturing) & fval_fall;
    end
  end

  // ==========================================================
  // Coordinates and outputs
  // ==========================================================
  always_ff @(posedge ccd_pixel_clk) begin
    bayer.sample <= acc_data;
    bayer.col    <= col_cnt;
    bayer.row    <= row_cnt;
    if (!hps_fpga_reset_n) begin
      bayer.valid <= 1'b0;
      frame_done  <= 1'b0;
      col_cnt     <= '0;
      row_cnt     <= '0;
      line_seen   <= 1'b0;
    end else begin
      bayer.valid <= acc_valid;
      frame_done  <= acc_end;
      if (acc_valid) begin
        col_cnt   <= col_cnt + 1'b1;
        line_seen <= 1'b1;
      end else if (!acc_lval) begin
        // Line blanking, next line starts at column zero
        col_cnt   <= '0;
        line_seen <= 1'b0;
        if (line_seen) begin
          row_cnt <= row_cnt + 1'b1;
        end
      end
      // New frame restarts row numbering
      if (acc_start) begin
        row_cnt   <= '0;
        line_seen <= 1'b0;
      end
    end
  end

endmodule

// ==== design/bayer_demosaic.sv ====
// ==========================================================
// Bayer to RGB demosaic
// ==========================================================
`timescale 1ns/1ns
`include "camera_config.svh"

module bayer_demosaic #(
  parameter int max_line_width = `CAM_LINE_W
) (
  input  logic ccd_pixel_clk,
  input  logic hps_fpga_reset_n,
  bayer_if.dst bayer,
  rgb_if.src   rgb
);
  import camera_pkg::*;

  localparam int addr_w = (max_line_width > 1) ? $clog2(max_line_width) : 1;

  // Even-row samples, G at even columns and R at odd columns
  sample_t line_buf [max_line_width];

  // Blue sample of the current odd row
  sample_t blue_hold;

  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] red_addr;
  logic [addr_w-1:0] green_addr;
  sample_t red_buf;
  sample_t green_buf;
  logic [$bits(sample_t):0] green_sum;
  logic odd_row;
  logic odd_col;
  logic in_range;
  logic pix_done;

  assign odd_row  = bayer.row[0];
  assign odd_col  = bayer.col[0];
  assign in_range = (bayer.col < max_line_width);

  // Buffer addresses of the current two-by-two block
  assign wr_addr    = bayer.col[addr_w-1:0];
  assign red_addr   = bayer.col[addr_w-1:0];
  assign green_addr = {bayer.col[addr_w-1:1], 1'b0};

  assign red_buf   = line_buf[red_addr];
  assign green_buf = line_buf[green_addr];

  // Mean of the two greens, rounded down
  assign green_sum = {1'b0, green_buf} + {1'b0, bayer.sample};

  // Block completes on the odd column of an odd row
  assign pix_done = bayer.valid & odd_row & odd_col;

  // ==========================================================
  // Line buffer and blue hold
  // ==========================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (bayer.valid && !odd_row && in_range) begin
      line_buf[wr_addr] <= bayer.sample;
    end
    if (bayer.valid && odd_row && !odd_col) begin
      blue_hold <= bayer.sample;
    end
  end

  // ==========================================================
  // RGB output
  // ==========================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (pix_done) begin
      rgb.red   <= red_buf;
      rgb.green <= green_sum[$bits(sample_t):1];
      rgb.blue  <= blue_hold;
    end
    if (!hps_fpga_reset_n) begin
      rgb.valid <= 1'b0;
    end else begin
      // One pixel per block, half width and half height
      rgb.valid <= pix_done;
    end
  end

endmodule

// ==== design/pixel_formatter.sv ====
// ==========================================================
// Hue pipeline and output packing
// ==========================================================
`timescale 1ns/1ns

module pixel_formatter (
  input  logic                    ccd_pixel_clk,
  input  logic                    hps_fpga_reset_n,
  rgb_if.dst                      rgb,
  input  camera_pkg::out_fmt_e    fmt,
  output camera_pkg::pixel_word_t pixel_word,
  output logic                    pixel_valid
);
  import camera_pkg::*;

  // Top 8 bits of each channel
  chan8_t r_in;
  chan8_t g_in;
  chan8_t b_in;
  chan8_t max_c;
  chan8_t min_c;
  hue_sector_e sector_c;

  // Stage 1 registers
  logic        s1_valid;
  chan8_t      s1_r;
  chan8_t      s1_g;
  chan8_t      s1_b;
  chan8_t      s1_range;
  hue_sector_e s1_sector;

  // Stage 2 registers
  logic   s2_valid;
  chan8_t s2_r;
  chan8_t s2_g;
  chan8_t s2_b;
  chan8_t s2_hue;

  logic signed [8:0]  diff;
  logic signed [15:0] prod;
  logic signed [15:0] denom;
  logic signed [15:0] quot;
  chan8_t base;
  chan8_t hue_c;

  assign r_in = rgb.red[$bits(sample_t)-1 -: 8];
  assign g_in = rgb.green[$bits(sample_t)-1 -: 8];
  assign b_in = rgb.blue[$bits(sample_t)-1 -: 8];

  // ==========================================================
  // Stage 1, max, min and sector
  // ==========================================================
  always_comb begin
    // Red wins ties, then green
    if (r_in >= g_in && r_in >= b_in) begin
      max_c    = r_in;
      sector_c = sector_red;
    end else if (g_in >= b_in) begin
      max_c    = g_in;
      sector_c = sector_green;
    end else begin
      max_c    = b_in;
      sector_c = sector_blue;
    end
    min_c = (r_in <= g_in) ? r_in : g_in;
    if (b_in < min_c) begin
      min_c = b_in;
    end
    if (max_c == min_c) begin
      sector_c = sector_gray;
    end
  end

  // ==========================================================
  // Stage 2, hue from sector base and scaled difference
  // ==========================================================
  always_comb begin
    case (s1_sector)
      sector_red: begin
        diff = $signed({1'b0, s1_g}) - $signed({1'b0, s1_b});
        base = 8'd0;
      end
      sector_green: begin
        diff = $signed({1'b0, s1_b}) - $signed({1'b0, s1_r});
        base = 8'd85;
      end
      sector_blue: begin
        diff = $signed({1'b0, s1_r}) - $signed({1'b0, s1_g});
        base = 8'd171;
      end
      default: begin
        diff = '0;
        base = 8'd0;
      end
    endcase
    prod  = diff * 16'sd43;
    // Gray has zero range, keep the divisor nonzero
    denom = (s1_range == 8'd0) ? 16'sd1 : $signed({8'd0, s1_range});
    // Signed divide truncates toward zero
    quot  = prod / denom;
    hue_c = (s1_sector == sector_gray) ? 8'd0 : base + quot[7:0];
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s1_r      <= r_in;
    s1_g      <= g_in;
    s1_b      <= b_in;
    s1_range  <= max_c - min_c;
    s1_sector <= sector_c;
    s2_r      <= s1_r;
    s2_g      <= s1_g;
    s2_b      <= s1_b;
    s2_hue    <= hue_c;
    // Stage 3, format select on the final word
    if (fmt == fmt_rgb555) begin
      pixel_word <= {1'b0, s2_r[7:3], s2_g[7:3], s2_b[7:3]};
    end else begin
      pixel_word <= {8'h00, s2_hue};
    end
    if (!hps_fpga_reset_n) begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      s1_valid    <= rgb.valid;
      s2_valid    <= s1_valid;
      pixel_valid <= s2_valid;
    end
  end

endmodule

// ==== design/frame_rate_meter.sv ====
// ==========================================================
// Frame rate meter and display
// ==========================================================
`timescale 1ns/1ns
`include "camera_config.svh"

module frame_rate_meter #(
  parameter int rate_window = `CAM_RATE_WINDOW
) (
  input  logic       ccd_pixel_clk,
  input  logic       hps_fpga_reset_n,
  input  logic       frame_done,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5,
  output logic       window_led
);

  localparam int win_w = $clog2(rate_window + 1);

  logic [win_w-1:0] win_cnt;
  logic [23:0]      frame_cnt;
  logic [23:0]      rate;
  logic             win_end;

  assign win_end = (win_cnt == win_w'(rate_window - 1));

  // Active-low segments, g down to a
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'b1000000;
      4'h1: seg7 = 7'b1111001;
      4'h2: seg7 = 7'b0100100;
      4'h3: seg7 = 7'b0110000;
      4'h4: seg7 = 7'b0011001;
      4'h5: seg7 = 7'b0010010;
      4'h6: seg7 = 7'b0000010;
      4'h7: seg7 = 7'b1111000;
      4'h8: seg7 = 7'b0000000;
      4'h9: seg7 = 7'b0010000;
      4'ha: seg7 = 7'b0001000;
      4'hb: seg7 = 7'b0000011;
      4'hc: seg7 = 7'b1000110;
      4'hd: seg7 = 7'b0100001;
      4'he: seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  // ==========================================================
  // Window counter and rate latch
  // ==========================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      win_cnt    <= '0;
      frame_cnt  <= '0;
      rate       <= '0;
      window_led <= 1'b0;
    end else if (win_end) begin
      // Pulse in the last cycle still belongs to this window
      rate       <= frame_cnt + 24'(frame_done);
      frame_cnt  <= '0;
      win_cnt    <= '0;
      window_led <= ~window_led;
    end else begin
      frame_cnt <= frame_cnt + 24'(frame_done);
      win_cnt   <= win_cnt + 1'b1;
    end
  end

  // Digits, hex0 least significant
  assign hex0 = seg7(rate[3:0]);
  assign hex1 = seg7(rate[7:4]);
  assign hex2 = seg7(rate[11:8]);
  assign hex3 = seg7(rate[15:12]);
  assign hex4 = seg7(rate[19:16]);
  assign hex5 = seg7(rate[23:20]);

endmodule

// ==== design/camera_top.sv ====
// ==========================================================
// Camera pixel path top level
// ==========================================================
`timescale 1ns/1ns
`include "camera_config.svh"

module camera_top #(
  parameter int max_line_width = `CAM_LINE_W,
  parameter int rate_window    = `CAM_RATE_WINDOW
) (
  input  logic        ccd_pixel_clk,
  input  logic        hps_fpga_reset_n,
  input  logic [11:0] ccd_data,
  input  logic        ccd_fval,
  input  logic        ccd_lval,
  input  logic        capture_start,
  input  logic        rgb_mode,
  output logic [15:0] pixel_word,
  output logic        pixel_valid,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5,
  output logic        window_led
);
  import camera_pkg::*;

  bayer_if bayer ();
  rgb_if   rgb ();

  logic     frame_done;
  out_fmt_e fmt;

  // Mode switch high selects RGB555
  assign fmt = rgb_mode ? fmt_rgb555 : fmt_hue;

  // Pins to Bayer sample stream
  frame_capture u_capture (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ccd_data         (ccd_data),
    .ccd_fval         (ccd_fval),
    .ccd_lval         (ccd_lval),
    .capture_start    (capture_start),
    .bayer            (bayer.src),
    .frame_done       (frame_done)
  );

  bayer_demosaic #(
    .max_line_width (max_line_width)
  ) u_demosaic (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .bayer            (bayer.dst),
    .rgb              (rgb.src)
  );

  pixel_formatter u_formatter (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .rgb              (rgb.dst),
    .fmt              (fmt),
    .pixel_word       (pixel_word),
    .pixel_valid      (pixel_valid)
  );

  // Frame rate on the seven-segment digits
  frame_rate_meter #(
    .rate_window (rate_window)
  ) u_rate (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .frame_done       (frame_done),
    .hex0             (hex0),
    .hex1             (hex1),
    .hex2             (hex2),
    .hex3             (hex3),
    .hex4             (hex4),
    .hex5             (hex5),
    .window_led       (window_led)
  );

endmodule

// ==== testbench/camera_tb.sv ====
// ==========================================================
// Camera pixel path testbench
// ==========================================================
`timescale 1ns/1ns

module camera_tb;

  localparam int line_w = 16;
  localparam int window = 600;

  // DUT pins
  logic        ccd_pixel_clk;
  logic        hps_fpga_reset_n;
  logic [11:0] ccd_data;
  logic        ccd_fval;
  logic        ccd_lval;
  logic        capture_start;
  logic        rgb_mode;
  logic [15:0] pixel_word;
  logic        pixel_valid;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;
  logic        window_led;

  // Stimulus words and the current frame's raw samples
  logic [15:0] stim [0:511];
  logic [11:0] samples [0:255];

  // Expected and observed words with the edge each appears on
  logic [15:0] exp_words [$];
  logic [15:0] got_words [$];
  int          exp_edges [$];
  int          got_edges [$];
  // Edge at which the rate meter counts each frame end
  int          end_edges [$];

  int     cyc = 0;
  int     release_edge;
  int     toggles = 0;
  int     errors = 0;
  int     timeouts = 0;
  int     ptr = 0;
  int     frame_no = 0;
  int     sector_hits [4];
  int     neg_hits = 0;
  integer seed;
  logic   led_prev = 1'b0;

  camera_top #(
    .max_line_width (line_w),
    .rate_window    (window)
  ) uut (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ccd_data         (ccd_data),
    .ccd_fval         (ccd_fval),
    .ccd_lval         (ccd_lval),
    .capture_start    (capture_start),
    .rgb_mode         (rgb_mode),
    .pixel_word       (pixel_word),
    .pixel_valid      (pixel_valid),
    .hex0             (hex0),
    .hex1             (hex1),
    .hex2             (hex2),
    .hex3             (hex3),
    .hex4             (hex4),
    .hex5             (hex5),
    .window_led       (window_led)
  );

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #2 ccd_pixel_clk = ~ccd_pixel_clk;
  end

  // Rising edge count starting at 1
  always @(posedge ccd_pixel_clk) begin
    cyc <= cyc + 1;
  end

  // Next word of the stim file
  function automatic logic [15:0] take_word();
    take_word = stim[ptr];
    ptr = ptr + 1;
  endfunction

  // Active-low g..a pattern back to a digit
  // Bit 4 flags a pattern that is no digit
  function automatic logic [4:0] seg_digit(input logic [6:0] seg);
    case (seg)
      7'h40: seg_digit = 5'h00;
      7'h79: seg_digit = 5'h01;
      7'h24: seg_digit = 5'h02;
      7'h30: seg_digit = 5'h03;
      7'h19: seg_digit = 5'h04;
      7'h12: seg_digit = 5'h05;
      7'h02: seg_digit = 5'h06;
      7'h78: seg_digit = 5'h07;
      7'h00: seg_digit = 5'h08;
      7'h10: seg_digit = 5'h09;
      7'h08: seg_digit = 5'h0a;
      7'h03: seg_digit = 5'h0b;
      7'h46: seg_digit = 5'h0c;
      7'h21: seg_digit = 5'h0d;
      7'h06: seg_digit = 5'h0e;
      7'h0e: seg_digit = 5'h0f;
      default: seg_digit = 5'h10;
    endcase
  endfunction

  task automatic read_display(output logic [23:0] value, output logic bad);
    logic [4:0] d [6];
    int i;
    d[0] = seg_digit(hex0);
    d[1] = seg_digit(hex1);
    d[2] = seg_digit(hex2);
    d[3] = seg_digit(hex3);
    d[4] = seg_digit(hex4);
    d[5] = seg_digit(hex5);
    value = '0;
    bad = 1'b0;
    // hex5 is the most significant digit
    for (i = 5; i >= 0; i--) begin
      value = {value[19:0], d[i][3:0]};
      bad = bad | d[i][4];
    end
  endtask

  // ==========================================================
  // Reference model
  // ==========================================================
  task automatic model_pixel(input logic [11:0] red, input logic [11:0] green,
                             input logic [11:0] blue, input logic mode);
    int r;
    int g;
    int b;
    int mx;
    int mn;
    int d;
    int base;
    int sec;
    int hue;
    r = red[11:4];
    g = green[11:4];
    b = blue[11:4];
    // Max with red, green, blue priority
    if (r >= g && r >= b) begin
      mx = r;
      sec = 0;
      d = g - b;
      base = 0;
    end else if (g >= b) begin
      mx = g;
      sec = 1;
      d = b - r;
      base = 85;
    end else begin
      mx = b;
      sec = 2;
      d = r - g;
      base = 171;
    end
    mn = r;
    if (g < mn) mn = g;
    if (b < mn) mn = b;
    if (mx == mn) begin
      sec = 3;
      hue = 0;
    end else begin
      // Integer divide truncates toward zero before the 8-bit wrap
      hue = (base + (43 * d) / (mx - mn)) & 255;
      if (d < 0) neg_hits++;
    end
    sector_hits[sec]++;
    if (mode) begin
      exp_words.push_back({1'b0, red[11:7], green[11:7], blue[11:7]});
    end else begin
      exp_words.push_back(16'(hue));
    end
  endtask

  // One pixel per 2x2 block of G R over B G
  task automatic predict_frame(input int w, input int h, input logic mode);
    int r;
    int c;
    int gsum;
    logic [11:0] green;
    for (r = 1; r < h; r += 2) begin
      for (c = 1; c < w; c += 2) begin
        gsum = samples[(r - 1) * w + c - 1];
        gsum = gsum + samples[r * w + c];
        green = 12'(gsum / 2);
        model_pixel(samples[(r - 1) * w + c], green, samples[r * w + c - 1], mode);
      end
    end
  endtask

  // A quarter of the random blocks are flat so that gray pixels appear
  task automatic make_random_frame(input int w, input int h);
    int r;
    int c;
    logic [11:0] v;
    for (r = 0; r < h; r += 2) begin
      for (c = 0; c < w; c += 2) begin
        if (($random(seed) & 3) == 0) begin
          v = $random(seed);
          samples[r * w + c]           = v;
          samples[r * w + c + 1]       = v;
          samples[(r + 1) * w + c]     = v;
          samples[(r + 1) * w + c + 1] = v;
        end else begin
          samples[r * w + c]           = $random(seed);
          samples[r * w + c + 1]       = $random(seed);
          samples[(r + 1) * w + c]     = $random(seed);
          samples[(r + 1) * w + c + 1] = $random(seed);
        end
      end
    end
  endtask

  // ==========================================================
  // Frame driver
  // ==========================================================
  // Start level 0 is low and 1 is high
  // Level 2 raises start at row 2 of a running frame
  task automatic drive_frame(input int w, input int h, input int start,
                             input logic mode, input int lgap, input int fgap);
    int r;
    int c;
    int i;
    @(negedge ccd_pixel_clk);
    capture_start = (start == 1);
    rgb_mode      = mode;
    ccd_fval      = 1'b0;
    ccd_lval      = 1'b0;
    // Frame valid leads line valid by one cycle
    @(negedge ccd_pixel_clk);
    ccd_fval = 1'b1;
    for (r = 0; r < h; r++) begin
      for (c = 0; c < w; c++) begin
        @(negedge ccd_pixel_clk);
        ccd_lval = 1'b1;
        ccd_data = samples[r * w + c];
        if (start == 2 && r == 2 && c == 0) begin
          capture_start = 1'b1;
        end
        // Word out 6 edges after the sampling edge
        if (start == 1 && (r % 2) == 1 && (c % 2) == 1) begin
          exp_edges.push_back(cyc + 7);
        end
      end
      for (i = 0; i < lgap; i++) begin
        @(negedge ccd_pixel_clk);
        ccd_lval = 1'b0;
      end
    end
    @(negedge ccd_pixel_clk);
    ccd_fval = 1'b0;
    // frame_done rises 2 edges after the fval low sample
    // The meter counts it one edge later
    if (start == 1) begin
      end_edges.push_back(cyc + 4);
    end
    for (i = 0; i < fgap; i++) begin
      @(negedge ccd_pixel_clk);
    end
  endtask

  // ==========================================================
  // Checks
  // ==========================================================
  task automatic check_frame();
    int wait_cnt;
    logic [15:0] e;
    logic [15:0] g;
    int ee;
    int ge;
    wait_cnt = 0;
    while (got_words.size() < exp_words.size() && wait_cnt < 200) begin
      @(negedge ccd_pixel_clk);
      wait_cnt++;
    end
    if (got_words.size() < exp_words.size()) begin
      $display("Timeout waiting for the pixel words of frame %0d", frame_no);
      timeouts++;
    end else if (got_words.size() != exp_words.size()) begin
      $display("[FAIL] pixel_valid count frame %0d exp %h got %h",
               frame_no, exp_words.size(), got_words.size());
      errors++;
    end
    while (exp_words.size() > 0 && got_words.size() > 0) begin
      e = exp_words.pop_front();
      g = got_words.pop_front();
      if (g !== e) begin
        $display("[FAIL] pixel_word frame %0d exp %h got %h", frame_no, e, g);
        errors++;
      end
    end
    while (exp_edges.size() > 0 && got_edges.size() > 0) begin
      ee = exp_edges.pop_front();
      ge = got_edges.pop_front();
      if (ge != ee) begin
        $display("[FAIL] pixel_valid edge frame %0d exp %h got %h", frame_no, ee, ge);
        errors++;
      end
    end
    exp_words.delete();
    got_words.delete();
    exp_edges.delete();
    got_edges.delete();
    frame_no++;
  endtask

  // Window just ended at edge cyc
  task automatic check_window();
    int exp_edge;
    int frames;
    logic [23:0] shown;
    logic bad;
    exp_edge = release_edge + window - 1 + window * toggles;
    if (cyc != exp_edge) begin
      $display("[FAIL] window_led toggle edge exp %h got %h", exp_edge, cyc);
      errors++;
    end
    frames = 0;
    while (end_edges.size() > 0 && end_edges[0] <= cyc) begin
      end_edges.delete(0);
      frames++;
    end
    read_display(shown, bad);
    if (bad) begin
      $display("A seven-segment digit shows a pattern that is no hex digit");
      errors++;
    end else if (shown !== 24'(frames)) begin
      $display("[FAIL] hex5..hex0 exp %h got %h", 24'(frames), shown);
      errors++;
    end
    toggles++;
  endtask

  task automatic wait_windows(input int n);
    int target;
    int wait_cnt;
    target = toggles + n;
    wait_cnt = 0;
    while (toggles < target && wait_cnt < n * window + 100) begin
      @(negedge ccd_pixel_clk);
      wait_cnt++;
    end
    if (toggles < target) begin
      $display("Timeout waiting for %0d window_led toggles", n);
      timeouts++;
    end
  endtask

  // Word collector and window monitor on the falling edge
  always @(negedge ccd_pixel_clk) begin
    if (hps_fpga_reset_n === 1'b1) begin
      if (pixel_valid === 1'b1) begin
        got_words.push_back(pixel_word);
        got_edges.push_back(cyc);
      end
      if (window_led !== led_prev) begin
        check_window();
      end
      led_prev = window_led;
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    logic [15:0] kind;
    logic [23:0] shown;
    logic        bad;
    logic        running;
    int w;
    int h;
    int start;
    int mode;
    int lgap;
    int fgap;
    int n;
    int i;
    hps_fpga_reset_n = 1'b0;
    ccd_data         = '0;
    ccd_fval         = 1'b0;
    ccd_lval         = 1'b0;
    capture_start    = 1'b0;
    rgb_mode         = 1'b0;
    seed             = 17883;
    for (i = 0; i < 4; i++) begin
      sector_hits[i] = 0;
    end
    $readmemh("testbench/camera_stim.txt", stim);

    repeat (8) @(posedge ccd_pixel_clk);
    @(negedge ccd_pixel_clk);
    hps_fpga_reset_n = 1'b1;
    release_edge = cyc + 1;
    // Reset state of the display, LED and output strobe
    read_display(shown, bad);
    if (bad || shown !== 24'h0) begin
      $display("[FAIL] hex5..hex0 exp %h got %h", 24'h0, shown);
      errors++;
    end
    if (window_led !== 1'b0) begin
      $display("[FAIL] window_led exp %h got %h", 1'b0, window_led);
      errors++;
    end
    if (pixel_valid !== 1'b0) begin
      $display("[FAIL] pixel_valid exp %h got %h", 1'b0, pixel_valid);
      errors++;
    end

    running = 1'b1;
    while (running && ptr < 512) begin
      kind = take_word();
      case (kind)
        16'h0001, 16'h0002: begin
          w     = take_word();
          h     = take_word();
          start = take_word();
          mode  = take_word();
          lgap  = take_word();
          fgap  = take_word();
          if (kind == 16'h0001) begin
            for (i = 0; i < w * h; i++) begin
              samples[i] = take_word();
            end
            n = take_word();
            for (i = 0; i < n; i++) begin
              exp_words.push_back(take_word());
            end
          end else begin
            make_random_frame(w, h);
            if (start == 1) begin
              predict_frame(w, h, mode[0]);
            end
          end
          drive_frame(w, h, start, mode[0], lgap, fgap);
          check_frame();
        end
        16'h0003: begin
          wait_windows(take_word());
        end
        16'h0000: begin
          running = 1'b0;
        end
        default: begin
          $display("The stim file holds an unknown record kind at word %0d", ptr - 1);
          errors++;
          running = 1'b0;
        end
      endcase
    end

    // Random frames must reach every hue sector and a negative difference
    for (i = 0; i < 4; i++) begin
      if (sector_hits[i] == 0) begin
        $display("Random frames produced no pixel in hue sector %0d", i);
        errors++;
      end
    end
    if (neg_hits == 0) begin
      $display("Random frames produced no negative hue difference");
      errors++;
    end

    $display("Checks done: %0d errors, %0d timeouts, %0d windows", errors, timeouts, toggles);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/camera_stim.txt ====
// Hex records: kind w h start mode line_gap frame_gap, then w*h samples, count, words
// kind 1 file frame, 2 random frame, 3 windows to check then count, 0 end; start 2 = mid-frame
// RGB555 frame with the expected words
1 4 4 1 1 2 8
800 F00 A00 200
100 800 400 A10
600 200 555 55A
E00 601 55F 553
4 7A02 1288 119C 294A
// Same samples in hue mode, red green blue and gray pixels
1 4 4 1 0 3 A
800 F00 A00 200
100 800 400 A10
600 200 555 55A
E00 601 55F 553
4 0015 005F 009D 0000
// Capture start low, no words
1 4 4 0 1 2 8
800 F00 A00 200
100 800 400 A10
600 200 555 55A
E00 601 55F 553
0
// Start raised inside a running frame, no words
1 4 4 2 0 2 8
800 F00 A00 200
100 800 400 A10
600 200 555 55A
E00 601 55F 553
0
// Next frame is captured again in RGB555
1 4 4 1 1 2 8
800 F00 A00 200
100 800 400 A10
600 200 555 55A
E00 601 55F 553
4 7A02 1288 119C 294A
// Random hue frames, one with start low
2 8 4 1 0 2 8
2 8 4 1 0 1 6
2 10 4 1 0 2 8
2 8 6 1 0 3 8
2 8 4 0 0 2 8
2 10 2 1 0 2 8
3 1
// Mode switches between random frames
2 8 4 1 1 2 8
2 10 4 1 0 2 C
2 8 4 1 1 2 8
3 3
0

// ==== src.f ====
+incdir+design
design/camera_pkg.sv
design/pixel_if.sv
design/frame_capture.sv
design/bayer_demosaic.sv
design/pixel_formatter.sv
design/frame_rate_meter.sv
design/camera_top.sv
testbench/camera_tb.sv

// ==== Bender.yml ====
package:
  name: camera_pixel_path

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/camera_pkg.sv
      - design/pixel_if.sv
      - design/frame_capture.sv
      - design/bayer_demosaic.sv
      - design/pixel_formatter.sv
      - design/frame_rate_meter.sv
      - design/camera_top.sv
  - target: simulation
    files:
      - testbench/camera_tb.sv
